// ==== common/fieldStreamIf.sv ====
// Decoded field stream; payload must hold steady while valid is high and ready is low
interface fieldStreamIf;
  import ucodePkg::*;

  // Handshake
  logic valid;
  logic ready;

  // Field value, kind of the line it came from
  tField value;
  tRecType recType;
  // Last field of the line
  logic lineEnd;

  // Decoder side
  modport source (
    output valid, value, recType, lineEnd,
    input ready
  );

  // Parser side
  modport sink (
    input valid, value, recType, lineEnd,
    output ready
  );

endinterface

// ==== common/ramWordIf.sv ====
// Slot stream toward the assembler; address is meaningful only on the slot that ends a word
interface ramWordIf;
  import ucodePkg::*;

  // Handshake
  logic valid;
  logic ready;

  // One 16-bit piece of a RAM word
  tField value;
  tSlot slot;
  // High for control RAM, low for dispatch RAM
  logic isCram;
  // Dispatch RAM uses the low 8 bits
  tCramAddr address;

  // Parser side
  modport source (
    output valid, value, slot, isCram, address,
    input ready
  );

  // Assembler side
  modport sink (
    input valid, value, slot, isCram, address,
    output ready
  );

endinterface

// ==== common/ucodePkg.sv ====
// Shared widths and types for the load-file path; control-RAM bits are numbered 0 = MSB
package ucodePkg;

  ////////////////////////////////////////
  // Widths

  // Decoded field and checksum
  localparam int fieldWidth = 16;
  // Input character
  localparam int charWidth = 8;
  // Control-RAM word, bit 0 is the most significant
  localparam int cramWordWidth = 86;
  localparam int cramAddrWidth = 11;
  localparam int dramAddrWidth = 8;

  // Fields per stored word
  localparam int cramSlots = 6;
  localparam int dramSlots = 3;

  ////////////////////////////////////////
  // Characters with a meaning in the load file

  localparam logic [charWidth-1:0] charLf = 8'h0a;
  localparam logic [charWidth-1:0] charCr = 8'h0d;
  localparam logic [charWidth-1:0] charComma = 8'h2c;
  localparam logic [charWidth-1:0] charSemi = 8'h3b;
  localparam logic [charWidth-1:0] charC = 8'h43;
  localparam logic [charWidth-1:0] charD = 8'h44;
  localparam logic [charWidth-1:0] charZ = 8'h5a;

  ////////////////////////////////////////
  // Types

  typedef logic [fieldWidth-1:0] tField;

  // Record kind taken from the first character of a line
  typedef enum logic [1:0] {
    recCram,
    recDram,
    recZero,
    recUnknown
  } tRecType;

  // Machine bit order, 0 on the left
  typedef logic [0:cramWordWidth-1] tCramWord;

  typedef logic [cramAddrWidth-1:0] tCramAddr;
  typedef logic [dramAddrWidth-1:0] tDramAddr;

  // Slot index within one control-RAM word or dispatch-RAM pair
  typedef logic [2:0] tSlot;

endpackage

// ==== loader/ramWordAssembler.sv ====
// Assumes slots arrive in order per word; one finished word per kind can wait for its ready
module ramWordAssembler (
  input  logic clk,
  input  logic rst,
  ramWordIf.sink words,
  output logic cramValid,
  input  logic cramReady,
  output ucodePkg::tCramAddr cramAddr,
  output ucodePkg::tCramWord cramWord,
  output logic dramValid,
  input  logic dramReady,
  output ucodePkg::tDramAddr dramAddr,
  output ucodePkg::tField dramEven,
  output ucodePkg::tField dramOdd,
  output ucodePkg::tField dramCommon
);
  import ucodePkg::*;

  // Bits 0-79 of the control-RAM word being filled
  logic [0:cramWordWidth-7] cramStage;
  tField evenStage;
  tField oddStage;

  logic take;
  logic lastSlot;
  logic cramFree;
  logic dramFree;

  // Output register empty or emptying this cycle
  assign cramFree = !cramValid || cramReady;
  assign dramFree = !dramValid || dramReady;

  assign lastSlot = words.isCram ? (words.slot == tSlot'(cramSlots - 1))
                                 : (words.slot == tSlot'(dramSlots - 1));

  // Only the final slot needs room in the output register
  assign words.ready = !lastSlot || (words.isCram ? cramFree : dramFree);
  assign take = words.valid && words.ready;

  ////////////////////////////////////////
  // Output valid flags

  always_ff @(posedge clk) begin
    if (rst) begin
      cramValid <= 1'b0;
      dramValid <= 1'b0;
    end else begin
      if (cramValid && cramReady) begin
        cramValid <= 1'b0;
      end
      if (dramValid && dramReady) begin
        dramValid <= 1'b0;
      end
      if (take && lastSlot) begin
        if (words.isCram) begin
          cramValid <= 1'b1;
        end else begin
          dramValid <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Staging and output data

  always_ff @(posedge clk) begin
    if (take && words.isCram) begin
      if (lastSlot) begin
        // Last field brings the six special bits 80-85
        cramWord <= {cramStage, words.value[5:0]};
        cramAddr <= words.address;
      end else begin
        // Load file order 64-79, 48-63, 32-47, 16-31, 0-15
        case (words.slot)
          3'd0:    cramStage[64:79] <= words.value;
          3'd1:    cramStage[48:63] <= words.value;
          3'd2:    cramStage[32:47] <= words.value;
          3'd3:    cramStage[16:31] <= words.value;
          default: cramStage[0:15] <= words.value;
        endcase
      end
    end
    if (take && !words.isCram) begin
      if (lastSlot) begin
        // Common field closes the pair
        dramEven <= evenStage;
        dramOdd <= oddStage;
        dramCommon <= words.value;
        dramAddr <= words.address[dramAddrWidth-1:0];
      end else if (words.slot == 3'd0) begin
        evenStage <= words.value;
      end else begin
        oddStage <= words.value;
      end
    end
  end

  // Held words stay put under back-pressure
  assert property (@(posedge clk) disable iff (rst)
    cramValid && !cramReady |=> cramValid && $stable(cramWord) && $stable(cramAddr));

  assert property (@(posedge clk) disable iff (rst)
    dramValid && !dramReady |=> dramValid && $stable(dramAddr) && $stable(dramEven)
      && $stable(dramOdd) && $stable(dramCommon));

endmodule

// ==== loader/recordParser.sv ====
// Address continuation is per RAM kind; WC-zero, Z and unknown lines never move an address
module recordParser (
  input  logic clk,
  input  logic rst,
  fieldStreamIf.sink fields,
  ramWordIf.source words,
  output logic lineDone,
  output logic lineOk,
  output logic lineBadType
);
  import ucodePkg::*;

  // Which field of the line comes next
  typedef enum logic [1:0] {
    pWc,
    pAdr,
    pBody
  } tPos;

  tPos pos;
  tField remaining;
  tField sum;
  tField lineSum;
  tSlot slot;
  tCramAddr curAddr;
  tCramAddr nextAddr;
  tCramAddr startAddr;
  tCramAddr lastCram;
  tDramAddr lastDram;

  logic wValid;
  tField wValue;
  tSlot wSlot;
  logic wIsCram;
  tCramAddr wAddr;

  logic take;
  logic isCramLine;
  logic isData;
  logic endSlot;

  assign fields.ready = !wValid || words.ready;
  assign take = fields.valid && fields.ready;

  assign isCramLine = fields.recType == recCram;
  // Only C and D bodies carry RAM data, checksum field excluded
  assign isData = (isCramLine || fields.recType == recDram) && pos == pBody && remaining != '0;
  assign endSlot = isCramLine ? (slot == tSlot'(cramSlots - 1)) : (slot == tSlot'(dramSlots - 1));

  // Running sum includes the checksum field itself
  assign lineSum = sum + fields.value;

  // Control RAM steps by 1, dispatch RAM by a pair
  assign nextAddr = curAddr + (isCramLine ? tCramAddr'(1) : tCramAddr'(2));

  // ADR of zero continues from the previous line of this kind
  always_comb begin
    if (fields.value != '0) begin
      startAddr = fields.value[cramAddrWidth-1:0];
    end else if (isCramLine) begin
      startAddr = lastCram;
    end else begin
      startAddr = tCramAddr'(lastDram);
    end
  end

  ////////////////////////////////////////
  // Line tracking

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= pWc;
      remaining <= '0;
      sum <= '0;
      slot <= '0;
      curAddr <= '0;
      lastCram <= '0;
      lastDram <= '0;
      wValid <= 1'b0;
      lineDone <= 1'b0;
    end else begin
      lineDone <= 1'b0;
      if (wValid && words.ready) begin
        wValid <= 1'b0;
      end
      if (take) begin
        sum <= fields.lineEnd ? '0 : lineSum;
        case (pos)
          pWc: begin
            remaining <= fields.value;
            pos <= pAdr;
          end
          pAdr: begin
            curAddr <= startAddr;
            pos <= pBody;
          end
          default: begin
            if (isData) begin
              remaining <= remaining - 1'b1;
              wValid <= 1'b1;
              slot <= endSlot ? '0 : slot + 1'b1;
              // Word complete, remember where the next one goes
              if (endSlot) begin
                curAddr <= nextAddr;
                if (isCramLine) begin
                  lastCram <= nextAddr;
                end else begin
                  lastDram <= nextAddr[dramAddrWidth-1:0];
                end
              end
            end
          end
        endcase
        if (fields.lineEnd) begin
          pos <= pWc;
          slot <= '0;
          lineDone <= 1'b1;
        end
      end
    end
  end

  // Slot and status payload
  always_ff @(posedge clk) begin
    if (take && isData) begin
      wValue <= fields.value;
      wSlot <= slot;
      wIsCram <= isCramLine;
      wAddr <= endSlot ? curAddr : '0;
    end
    if (take && fields.lineEnd) begin
      lineOk <= lineSum == '0;
      lineBadType <= fields.recType == recUnknown;
    end
  end

  assign words.valid = wValid;
  assign words.value = wValue;
  assign words.slot = wSlot;
  assign words.isCram = wIsCram;
  assign words.address = wAddr;

  // Assembler relies on slots staying inside their word
  assert property (@(posedge clk) disable iff (rst)
    words.valid |-> words.slot < (words.isCram ? tSlot'(cramSlots) : tSlot'(dramSlots)));

endmodule

// ==== project.f ====
common/ucodePkg.sv
common/fieldStreamIf.sv
common/ramWordIf.sv
rtl/fieldDecoder.sv
loader/recordParser.sv
loader/ramWordAssembler.sv
rtl/ucodeLoader.sv
sim/ucodeLoaderTb.sv

// ==== rtl/fieldDecoder.sv ====
// Expects type letter then one separator per line; fields over 16 bits keep only the low 16
module fieldDecoder (
  input  logic clk,
  input  logic rst,
  input  logic charValid,
  input  logic [ucodePkg::charWidth-1:0] charData,
  output logic charReady,
  fieldStreamIf.source fields
);
  import ucodePkg::*;

  // Position within the current line
  typedef enum logic [1:0] {
    sType,
    sSep,
    sField,
    sSkip
  } tState;

  tState state;
  tField acc;
  tRecType lineType;
  tRecType charType;

  logic outValid;
  tField outValue;
  tRecType outType;
  logic outEnd;

  logic take;
  logic isLf;
  logic isTerm;

  // Stall only while a finished field is still waiting
  assign charReady = !outValid || fields.ready;
  assign take = charValid && charReady;
  assign isLf = charData == charLf;
  assign isTerm = isLf || (charData == charComma);

  // Map the type letter
  always_comb begin
    case (charData)
      charC:   charType = recCram;
      charD:   charType = recDram;
      charZ:   charType = recZero;
      default: charType = recUnknown;
    endcase
  end

  ////////////////////////////////////////
  // Line FSM

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= sType;
      outValid <= 1'b0;
      acc <= '0;
      lineType <= recUnknown;
    end else begin
      if (outValid && fields.ready) begin
        outValid <= 1'b0;
      end
      // Carriage return never affects anything
      if (take && charData != charCr) begin
        case (state)
          sType: begin
            if (charData == charSemi) begin
              state <= sSkip;
            end else if (!isLf) begin
              lineType <= charType;
              state <= sSep;
            end
          end
          sSep: begin
            acc <= '0;
            state <= isLf ? sType : sField;
          end
          sField: begin
            if (isTerm) begin
              // Field leaves next cycle, empty field gives 0
              outValid <= 1'b1;
              acc <= '0;
              if (isLf) begin
                state <= sType;
              end
            end else begin
              acc <= {acc[fieldWidth-7:0], charData[5:0]};
            end
          end
          default: begin
            // Comment line, wait for its end
            if (isLf) begin
              state <= sType;
            end
          end
        endcase
      end
    end
  end

  // Field payload
  always_ff @(posedge clk) begin
    if (take && state == sField && isTerm) begin
      outValue <= acc;
      outType <= lineType;
      outEnd <= isLf;
    end
  end

  assign fields.valid = outValid;
  assign fields.value = outValue;
  assign fields.recType = outType;
  assign fields.lineEnd = outEnd;

  // Stalled field must not change
  assert property (@(posedge clk) disable iff (rst)
    fields.valid && !fields.ready |=> fields.valid && $stable(fields.value));

endmodule

// ==== rtl/ucodeLoader.sv ====
// Load-file character stream in, RAM words out; lineDone pulses once per non-comment line
module ucodeLoader (
  input  logic clk,
  input  logic rst,
  // Character input
  input  logic charValid,
  output logic charReady,
  input  logic [ucodePkg::charWidth-1:0] charData,
  // Control-RAM words
  output logic cramValid,
  input  logic cramReady,
  output ucodePkg::tCramAddr cramAddr,
  output ucodePkg::tCramWord cramWord,
  // Dispatch-RAM pairs
  output logic dramValid,
  input  logic dramReady,
  output ucodePkg::tDramAddr dramAddr,
  output ucodePkg::tField dramEven,
  output ucodePkg::tField dramOdd,
  output ucodePkg::tField dramCommon,
  // Per-line status
  output logic lineDone,
  output logic lineOk,
  output logic lineBadType
);

  // Decoder to parser
  fieldStreamIf fieldBus ();
  // Parser to assembler
  ramWordIf wordBus ();

  fieldDecoder decoder (
    .clk       (clk),
    .rst       (rst),
    .charValid (charValid),
    .charData  (charData),
    .charReady (charReady),
    .fields    (fieldBus)
  );

  recordParser parser (
    .clk         (clk),
    .rst         (rst),
    .fields      (fieldBus),
    .words       (wordBus),
    .lineDone    (lineDone),
    .lineOk      (lineOk),
    .lineBadType (lineBadType)
  );

  ramWordAssembler assembler (
    .clk        (clk),
    .rst        (rst),
    .words      (wordBus),
    .cramValid  (cramValid),
    .cramReady  (cramReady),
    .cramAddr   (cramAddr),
    .cramWord   (cramWord),
    .dramValid  (dramValid),
    .dramReady  (dramReady),
    .dramAddr   (dramAddr),
    .dramEven   (dramEven),
    .dramOdd    (dramOdd),
    .dramCommon (dramCommon)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line appears
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module ucodeLoaderTb
out=$(./obj_dir/VucodeLoaderTb)
echo "$out"
echo "$out" | grep -qx '>>> PASS'

// ==== sim/ucodeLoaderTb.sv ====
// Builds load-file text with a reference model; needs Verilator --timing and --assert
module ucodeLoaderTb;
  import ucodePkg::*;

  localparam int charTimeout = 2000;
  localparam int drainTimeout = 5000;

  logic clk;
  logic rst;
  logic charValid;
  logic charReady;
  logic [charWidth-1:0] charData;
  logic cramValid;
  logic cramReady;
  tCramAddr cramAddr;
  tCramWord cramWord;
  logic dramValid;
  logic dramReady;
  tDramAddr dramAddr;
  tField dramEven;
  tField dramOdd;
  tField dramCommon;
  logic lineDone;
  logic lineOk;
  logic lineBadType;

  // Text still to send and the results expected in order
  logic [charWidth-1:0] charQ[$];
  tCramWord cramQ[$];
  tCramAddr cramAddrQ[$];
  string cramNameQ[$];
  tField evenQ[$];
  tField oddQ[$];
  tField commonQ[$];
  tDramAddr dramAddrQ[$];
  string dramNameQ[$];
  tRecType typeQ[$];
  logic okQ[$];
  string statNameQ[$];

  // Continuation addresses as the reference sees them
  tCramAddr lastCram;
  tDramAddr lastDram;
  string testName;
  logic hung;
  logic randomReady;
  logic [1:0] stallPat[0:255];

  int cramErrors;
  int dramErrors;
  int statusErrors;
  int resetErrors;
  int extraErrors;
  int timeoutErrors;

  ucodeLoader DUT (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  ////////////////////////////////////////
  // Reference model

  // Six bits per character with leading zero groups left out
  // A zero field is sent empty
  function automatic void pushField(input tField v);
    if (v[15:6] != '0) begin
      if (v[15:12] != '0) begin
        charQ.push_back(8'h40 | 8'(v[15:12]));
      end
      charQ.push_back(8'h40 | 8'(v[11:6]));
    end
    if (v != '0) begin
      charQ.push_back(8'h40 | 8'(v[5:0]));
    end
  endfunction

  function automatic void addComment(input string text);
    int i;
    charQ.push_back(8'h3b);
    for (i = 0; i < text.len(); i++) begin
      charQ.push_back(text[i]);
    end
    charQ.push_back(8'h0a);
  endfunction

  // One record line of wc data fields; badSum breaks the checksum by one
  function automatic void addLine(input logic [7:0] kind, input int wc, input int adr,
                                  input logic badSum);
    tField fl[0:63];
    tField sum;
    tCramAddr cramBase;
    tDramAddr dramBase;
    tCramWord word;
    tRecType expType;
    int i;
    int base;
    sum = '0;
    fl[0] = tField'(wc);
    fl[1] = tField'(adr);
    for (i = 0; i < wc; i++) begin
      fl[i + 2] = ($urandom % 8 == 0) ? '0 : tField'($urandom);
    end
    for (i = 0; i < wc + 2; i++) begin
      sum = sum + fl[i];
    end
    // Negated sum makes all fields add to zero
    fl[wc + 2] = tField'(badSum) - sum;
    // Type letter, separator, fields
    charQ.push_back(kind);
    charQ.push_back(8'h20);
    for (i = 0; i <= wc + 2; i++) begin
      pushField(fl[i]);
      if (i < wc + 2) begin
        charQ.push_back(8'h2c);
      end
    end
    if ($urandom % 2 == 1) begin
      charQ.push_back(8'h0d);
    end
    charQ.push_back(8'h0a);
    case (kind)
      "C":     expType = recCram;
      "D":     expType = recDram;
      "Z":     expType = recZero;
      default: expType = recUnknown;
    endcase
    typeQ.push_back(expType);
    okQ.push_back(!badSum);
    statNameQ.push_back(testName);
    if (expType == recCram && wc > 0) begin
      cramBase = (adr != 0) ? tCramAddr'(adr) : lastCram;
      for (i = 0; i < wc / cramSlots; i++) begin
        base = 2 + cramSlots * i;
        // Bits 0-15 come from the fifth field, 80-85 from the sixth
        word = {fl[base + 4], fl[base + 3], fl[base + 2], fl[base + 1], fl[base],
                fl[base + 5][5:0]};
        cramQ.push_back(word);
        cramAddrQ.push_back(cramBase + tCramAddr'(i));
        cramNameQ.push_back(testName);
      end
      lastCram = cramBase + tCramAddr'(wc / cramSlots);
    end
    if (expType == recDram && wc > 0) begin
      dramBase = (adr != 0) ? tDramAddr'(adr) : lastDram;
      for (i = 0; i < wc / dramSlots; i++) begin
        base = 2 + dramSlots * i;
        evenQ.push_back(fl[base]);
        oddQ.push_back(fl[base + 1]);
        commonQ.push_back(fl[base + 2]);
        // Pairs step by two
        dramAddrQ.push_back(dramBase + tDramAddr'(2 * i));
        dramNameQ.push_back(testName);
      end
      lastDram = dramBase + tDramAddr'(2 * (wc / dramSlots));
    end
  endfunction

  function automatic void addRandomLine();
    int pick;
    pick = $urandom % 7;
    case (pick)
      0, 1: addLine("C", cramSlots * (1 + $urandom % 3),
                    ($urandom % 2 == 1) ? 0 : 1 + $urandom % 2000, $urandom % 8 == 0);
      2, 3: addLine("D", dramSlots * (1 + $urandom % 4),
                    ($urandom % 2 == 1) ? 0 : 1 + $urandom % 250, $urandom % 8 == 0);
      4:    addLine(($urandom % 2 == 1) ? "Z" : "Q", 1 + $urandom % 3,
                    1 + $urandom % 500, $urandom % 8 == 0);
      5:    addLine(($urandom % 2 == 1) ? "C" : "D", 0, 0, 1'b0);
      default: addComment("random comment, ignored");
    endcase
  endfunction

  ////////////////////////////////////////
  // Stimulus

  task automatic sendChar(input logic [charWidth-1:0] c);
    int waited;
    waited = 0;
    charValid <= 1'b1;
    charData <= c;
    @(posedge clk);
    while (!charReady && waited < charTimeout) begin
      waited++;
      @(posedge clk);
    end
    if (!charReady) begin
      hung = 1'b1;
      timeoutErrors++;
      $display("ERROR: character input stalled for %0d cycles", charTimeout);
    end
  endtask

  // Send all queued text, then wait until every expected result has come out
  task automatic runQueued();
    int waited;
    while (charQ.size() > 0 && !hung) begin
      sendChar(charQ.pop_front());
    end
    charValid <= 1'b0;
    waited = 0;
    while (cramQ.size() + evenQ.size() + typeQ.size() > 0 && !hung
           && waited < drainTimeout) begin
      @(negedge clk);
      waited++;
    end
    if (!hung && cramQ.size() + evenQ.size() + typeQ.size() > 0) begin
      hung = 1'b1;
      timeoutErrors++;
      $display("ERROR: %0d control words, %0d dispatch pairs, %0d line results never came",
               cramQ.size(), evenQ.size(), typeQ.size());
    end
    // Idle time so stray outputs get caught
    repeat (10) @(posedge clk);
  endtask

  // Output back-pressure from a pattern filled after seeding
  initial begin
    logic [7:0] patIdx;
    cramReady = 1'b1;
    dramReady = 1'b1;
    patIdx = '0;
    forever begin
      @(posedge clk);
      if (randomReady) begin
        cramReady <= stallPat[patIdx][1];
        dramReady <= stallPat[patIdx][0];
        patIdx <= patIdx + 8'd1;
      end else begin
        cramReady <= 1'b1;
        dramReady <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Compare

  task automatic checkCram(input string name, input tCramAddr expAddr, input tCramWord expWord);
    if (cramAddr !== expAddr || cramWord !== expWord) begin
      cramErrors++;
      $display("FAILED %s: control RAM expected %h at %h, actual %h at %h",
               name, expWord, expAddr, cramWord, cramAddr);
    end
  endtask

  task automatic checkDram(input string name, input tDramAddr expAddr, input tField expEven,
                           input tField expOdd, input tField expCommon);
    if (dramAddr !== expAddr || dramEven !== expEven || dramOdd !== expOdd
        || dramCommon !== expCommon) begin
      dramErrors++;
      $display("FAILED %s: dispatch RAM expected %h %h %h at %h, actual %h %h %h at %h",
               name, expEven, expOdd, expCommon, expAddr,
               dramEven, dramOdd, dramCommon, dramAddr);
    end
  endtask

  task automatic checkStatus(input string name, input tRecType expType, input logic expOk);
    logic expBad;
    expBad = expType == recUnknown;
    if (lineOk !== expOk || lineBadType !== expBad) begin
      statusErrors++;
      $display("FAILED %s: status expected ok %b badType %b, actual ok %b badType %b",
               name, expOk, expBad, lineOk, lineBadType);
    end
  endtask

  // Ready for characters and nothing pending once reset is over
  task automatic checkIdle();
    if (charReady !== 1'b1 || cramValid !== 1'b0 || dramValid !== 1'b0
        || lineDone !== 1'b0) begin
      resetErrors++;
      $display("FAILED reset: expected rdy 1 valid 00 done 0, actual rdy %b valid %b%b done %b",
               charReady, cramValid, dramValid, lineDone);
    end
  endtask

  // Values read here are the ones settled before the edge
  initial begin
    forever begin
      @(posedge clk);
      if (!rst) begin
        if (cramValid && cramReady) begin
          if (cramQ.size() == 0) begin
            extraErrors++;
            $display("ERROR: control RAM word at %h came out with none expected", cramAddr);
          end else begin
            checkCram(cramNameQ.pop_front(), cramAddrQ.pop_front(), cramQ.pop_front());
          end
        end
        if (dramValid && dramReady) begin
          if (evenQ.size() == 0) begin
            extraErrors++;
            $display("ERROR: dispatch RAM pair at %h came out with none expected", dramAddr);
          end else begin
            checkDram(dramNameQ.pop_front(), dramAddrQ.pop_front(), evenQ.pop_front(),
                      oddQ.pop_front(), commonQ.pop_front());
          end
        end
        if (lineDone) begin
          if (typeQ.size() == 0) begin
            extraErrors++;
            $display("ERROR: line status pulse with no line expected");
          end else begin
            checkStatus(statNameQ.pop_front(), typeQ.pop_front(), okQ.pop_front());
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // Test sequence

  initial begin
    int i;
    rst = 1'b1;
    charValid = 1'b0;
    charData = '0;
    hung = 1'b0;
    randomReady = 1'b0;
    lastCram = '0;
    lastDram = '0;
    cramErrors = 0;
    dramErrors = 0;
    statusErrors = 0;
    resetErrors = 0;
    extraErrors = 0;
    timeoutErrors = 0;
    void'($urandom(32'h1055_36ae));
    for (i = 0; i < 256; i++) begin
      stallPat[i] = {$urandom % 3 != 0, $urandom % 3 != 0};
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    checkIdle();

    testName = "cramTwoWords";
    addLine("C", 12, 'h123, 1'b0);
    runQueued();

    testName = "dramThreePairs";
    addLine("D", 9, 'h40, 1'b0);
    runQueued();

    // ADR zero picks up where the same kind stopped
    testName = "addrContinue";
    addLine("C", 6, 0, 1'b0);
    addLine("D", 6, 0, 1'b0);
    addLine("C", 12, 0, 1'b0);
    addLine("D", 3, 0, 1'b0);
    runQueued();

    testName = "badChecksum";
    addLine("C", 6, 'h200, 1'b1);
    addLine("D", 3, 'h10, 1'b1);
    runQueued();

    // Six data fields would fill a whole control word or two dispatch pairs
    testName = "noWrites";
    addLine("Q", 6, 'h10, 1'b0);
    addLine("Z", 6, 'h300, 1'b0);
    addComment("comment, with commas");
    addLine("C", 0, 0, 1'b0);
    addLine("D", 0, 0, 1'b0);
    // Addresses unchanged by the lines above
    addLine("C", 6, 0, 1'b0);
    addLine("D", 3, 0, 1'b0);
    runQueued();

    testName = "randomMix";
    randomReady = 1'b1;
    for (i = 0; i < 40; i++) begin
      testName = $sformatf("randomMix%0d", i);
      addRandomLine();
    end
    runQueued();

    $display("errors: cram %0d, dram %0d, status %0d, reset %0d, extra %0d, timeout %0d",
             cramErrors, dramErrors, statusErrors, resetErrors, extraErrors, timeoutErrors);
    if (cramErrors + dramErrors + statusErrors + resetErrors + extraErrors
        + timeoutErrors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
